// File: Bender.yml
package:
  name: spi_slave

sources:
  - hw/spi_slave_pkg.sv
  - hw/spi_slave_io.sv
  - hw/spi_regfile.sv
  - hw/spi_slave.sv
  - target: test
    files:
      - bench/spi_slave_asserts.sv
      - bench/tb_spi_slave.sv

// File: bench/spi_slave_asserts.sv
//################################################
// concurrent checks on the spi slave interface
// bus side tracker of the command byte
// write strobe gating and miso quiet rule
// address step per data byte
// bind into spi_slave_io
//################################################

`timescale 1ns/1ps
`default_nettype none

module spi_slave_io_asserts (
   input wire logic                        sclk,
   input wire logic                        ss,
   input wire logic                        mosi,
   input wire logic                        lsbfirst,
   input wire spi_slave_pkg::spi_state_e   state,
   input wire spi_slave_pkg::spi_cmd_t     cmd,       // opcode and running address
   input wire logic                        data_done, // data byte complete
   input wire logic                        wr_write,
   input wire logic                        miso
);

   int unsigned                       fail_cnt = 0; // failures so far
   logic [3:0]                        edge_cnt;     // rising edges since select, stops at 8
   logic [spi_slave_pkg::BYTE_W-1:0]  cmd_sh;       // command byte seen on mosi
   logic                              cmd_seen;
   logic [spi_slave_pkg::ADDR_W-1:0]  addr_inc;     // 6 bit wrap
   logic                              rd_op;

   // command byte as the master sent it
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         edge_cnt <= 4'd0;
         cmd_sh   <= '0;
      end else if (edge_cnt != 4'd8) begin
         edge_cnt <= edge_cnt + 4'd1;
         if (lsbfirst) begin
            cmd_sh <= {mosi, cmd_sh[spi_slave_pkg::BYTE_W-1:1]};
         end else begin
            cmd_sh <= {cmd_sh[spi_slave_pkg::BYTE_W-2:0], mosi};
         end
      end
   end

   assign cmd_seen = (edge_cnt == 4'd8);
   assign rd_op    = cmd_seen && (cmd_sh[spi_slave_pkg::BYTE_W-1 -: 2] == spi_slave_pkg::OP_READ);
   assign addr_inc = cmd.addr + 1'b1;

   // strobe only once the command is in
   wr_only_in_data: assert property (
      @(negedge sclk) disable iff (ss)
         wr_write |-> cmd_seen && (state == spi_slave_pkg::DATA))
      else begin
         fail_cnt++;
         $error("write strobe high outside the DATA state");
      end

   // no strobe while deselected
   wr_low_when_idle: assert property (@(negedge sclk) ss |-> !wr_write)
      else begin
         fail_cnt++;
         $error("write strobe high while ss is high");
      end

   // miso quiet for write and nop opcodes
   miso_low_unless_read: assert property (@(posedge sclk) !rd_op |-> !miso)
      else begin
         fail_cnt++;
         $error("miso high outside a read");
      end

   // one step per data byte
   addr_steps_by_one: assert property (
      @(negedge sclk) disable iff (ss) data_done |=> (cmd.addr == $past(addr_inc)))
      else begin
         fail_cnt++;
         $error("address did not step by one across a data byte");
      end

endmodule

bind spi_slave_io spi_slave_io_asserts i_spi_slave_io_asserts (
   .sclk      (sclk),
   .ss        (ss),
   .mosi      (mosi),
   .lsbfirst  (lsbfirst),
   .state     (state_q),
   .cmd       (cmd_q),
   .data_done (data_done_q),
   .wr_write  (wr.write),
   .miso      (miso)
);

`default_nettype wire

// File: bench/tb_spi_slave.sv
//################################################
// testbench for the spi slave
// mode 0 master tasks in both bit orders
// reference register model and checks
// watchdog and summary line
//################################################

`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave;

   logic                               sclk;
   logic                               ss;
   logic                               mosi;
   logic                               lsbfirst;
   logic                               miso;
   spi_slave_pkg::reg_image_t          regs;

   logic [spi_slave_pkg::BYTE_W-1:0]   model [spi_slave_pkg::NUM_REGS]; // expected contents
   logic [spi_slave_pkg::BYTE_W-1:0]   tx_buf [8];   // data bytes of a burst
   logic [spi_slave_pkg::BYTE_W-1:0]   rx_buf [8];   // miso bytes of a burst
   int                                 errors = 0;
   int                                 last_fails = 0;
   int                                 tests = 0;
   int                                 failed_tests = 0;

   spi_slave i_spi_slave (
      .sclk     (sclk),
      .ss       (ss),
      .mosi     (mosi),
      .lsbfirst (lsbfirst),
      .miso     (miso),
      .regs     (regs)
   );

   // 40 ns sclk
   initial begin
      sclk = 1'b0;
      forever #20 sclk = ~sclk;
   end

   // watchdog covers 12 nine-byte transactions and reset twice over
   initial begin
      int unsigned limit_ns;
      limit_ns = 2 * (12 * 9 * 8 * 40 + 16 * 40);
      #(limit_ns);
      $display("timeout: transfers did not complete within %0d ns", limit_ns);
      $display(">>> FAIL");
      $finish;
   end

   //################################################
   // master side
   //################################################

   function automatic int assertion_fails();
      return i_spi_slave.i_spi_slave_io.i_spi_slave_io_asserts.fail_cnt;
   endfunction

   // mosi set 2 ns after each rising edge and miso read 2 ns after the next
   task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
      int i;
      rx = '0;
      for (i = 0; i < nbits; i++) begin
         mosi = lsbfirst ? tx[i] : tx[7 - i];
         @(posedge sclk);
         #2;
         if (lsbfirst) begin
            rx[i] = miso;
         end else begin
            rx[7 - i] = miso;
         end
      end
   endtask

   task automatic start_txn();
      @(posedge sclk);
      #2;
      ss = 1'b0;
   endtask

   // one more rising edge so the last write lands first
   task automatic end_txn();
      @(posedge sclk);
      #2;
      ss   = 1'b1;
      mosi = 1'b0;
      repeat (2) @(posedge sclk);
      #2;
   endtask

   task automatic run_burst(input logic [1:0] op, input logic [5:0] start, input int n);
      logic [7:0] rx;
      int         k;
      start_txn();
      shift_bits({op, start}, 8, rx);  // command byte
      for (k = 0; k < n; k++) begin
         shift_bits(tx_buf[k], 8, rx);
         rx_buf[k] = rx;
      end
      end_txn();
   endtask

   task automatic fill_random(input int n);
      int k;
      for (k = 0; k < n; k++) begin
         tx_buf[k] = 8'($urandom);
      end
   endtask

   //################################################
   // reference model and checks
   //################################################

   // writes below 16 land and the address wraps mod 64
   task automatic model_apply(input logic [1:0] op, input int start, input int n);
      int a;
      int k;
      a = start;
      if (op == spi_slave_pkg::OP_WRITE) begin
         for (k = 0; k < n; k++) begin
            if (a < spi_slave_pkg::NUM_REGS) begin
               model[a] = tx_buf[k];
            end
            a = (a + 1) % 64;
         end
      end
   endtask

   task automatic check_regs();
      int i;
      for (i = 0; i < spi_slave_pkg::NUM_REGS; i++) begin
         assert (regs[i] === model[i]) else begin
            $display("[ERROR] %0t ns regs[%0d] expected %h got %h",
                     $time, i, model[i], regs[i]);
            errors++;
         end
      end
   endtask

   task automatic check_reads(input int start, input int n);
      logic [7:0] exp;
      int         a;
      int         k;
      a = start;
      for (k = 0; k < n; k++) begin
         exp = (a < spi_slave_pkg::NUM_REGS) ? model[a] : 8'h00; // zero out of range
         assert (rx_buf[k] === exp) else begin
            $display("[ERROR] %0t ns miso byte %0d expected %h got %h",
                     $time, k, exp, rx_buf[k]);
            errors++;
         end
         a = (a + 1) % 64;
      end
   endtask

   task automatic check_quiet(input int n);
      int k;
      for (k = 0; k < n; k++) begin
         assert (rx_buf[k] === 8'h00) else begin
            $display("[ERROR] %0t ns miso byte %0d expected 00 got %h", $time, k, rx_buf[k]);
            errors++;
         end
      end
   endtask

   task automatic finish_test(input string name);
      int fails;
      fails = errors + assertion_fails();
      tests++;
      if (fails != last_fails) begin
         failed_tests++;
         $display("test %0d %s: failed", tests, name);
      end else begin
         $display("test %0d %s: ok", tests, name);
      end
      last_fails = fails;
   endtask

   //################################################
   // test sequence
   //################################################

   initial begin
      logic [7:0] rx;
      ss       = 1'b1;
      mosi     = 1'b0;
      lsbfirst = 1'b0;
      void'($urandom(10));
      repeat (16) @(posedge sclk);
      #2;

      // registers come up unknown so fill them all
      fill_random(8);
      run_burst(spi_slave_pkg::OP_WRITE, 6'd0, 8);
      model_apply(spi_slave_pkg::OP_WRITE, 0, 8);
      fill_random(8);
      run_burst(spi_slave_pkg::OP_WRITE, 6'd8, 8);
      model_apply(spi_slave_pkg::OP_WRITE, 8, 8);
      check_regs();
      finish_test("preload");

      fill_random(1);
      run_burst(spi_slave_pkg::OP_WRITE, 6'd3, 1);
      model_apply(spi_slave_pkg::OP_WRITE, 3, 1);
      check_regs();
      finish_test("single write msb first");

      fill_random(4);
      run_burst(spi_slave_pkg::OP_WRITE, 6'd14, 4);  // 16 and 17 dropped
      model_apply(spi_slave_pkg::OP_WRITE, 14, 4);
      check_regs();
      finish_test("burst write past the file");

      run_burst(spi_slave_pkg::OP_READ, 6'd0, 6);
      check_reads(0, 6);
      lsbfirst = 1'b1;                                 // changed while deselected
      fill_random(6);
      run_burst(spi_slave_pkg::OP_WRITE, 6'd0, 6);
      model_apply(spi_slave_pkg::OP_WRITE, 0, 6);
      check_regs();
      run_burst(spi_slave_pkg::OP_READ, 6'd0, 6);
      check_reads(0, 6);
      lsbfirst = 1'b0;
      finish_test("read back both orders");

      run_burst(spi_slave_pkg::OP_READ, 6'd62, 4);   // 62 and 63 read zero then wrap to 0
      check_reads(62, 4);
      finish_test("read wrap out of range");

      // five bits then deselect
      start_txn();
      shift_bits({spi_slave_pkg::OP_WRITE, 6'd7}, 8, rx);
      shift_bits(~model[7], 5, rx);
      ss   = 1'b1;
      mosi = 1'b0;
      repeat (2) @(posedge sclk);
      #2;
      check_regs();
      fill_random(1);
      run_burst(spi_slave_pkg::OP_WRITE, 6'd7, 1);
      model_apply(spi_slave_pkg::OP_WRITE, 7, 1);
      check_regs();
      finish_test("aborted byte");

      fill_random(4);
      run_burst(2'b01, 6'd2, 4);
      model_apply(2'b01, 2, 4);
      check_quiet(4);
      check_regs();
      fill_random(4);
      run_burst(2'b11, 6'd9, 4);
      model_apply(2'b11, 9, 4);
      check_quiet(4);
      check_regs();
      finish_test("nop opcodes");

      $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
               tests, failed_tests, errors, assertion_fails());
      if (failed_tests == 0 && errors == 0 && assertion_fails() == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/spi_regfile.sv
//################################################
// register file behind the spi slave
// per-register write decode, falling sclk
// read mux with zero for out of range
// register image for the core
//################################################

`timescale 1ns/1ps
`default_nettype none

module spi_regfile (
   input  wire logic                                sclk,
   input  wire spi_slave_pkg::reg_wr_t              wr,
   input  wire logic [spi_slave_pkg::ADDR_W-1:0]    addr,
   output logic [spi_slave_pkg::BYTE_W-1:0]         rdata,
   output spi_slave_pkg::reg_image_t                regs
);

   logic [spi_slave_pkg::NUM_REGS-1:0] wr_en;     // one hot or zero
   logic                               rd_in_range;

   //################################################
   // write decode
   //################################################

   // full 6 bit compare so addresses 16..63 hit nothing
   always_comb begin
      for (int i = 0; i < spi_slave_pkg::NUM_REGS; i++) begin
         wr_en[i] = wr.write && (wr.addr == i);
      end
   end

   // storage keeps its contents across ss
   always_ff @(negedge sclk) begin
      for (int i = 0; i < spi_slave_pkg::NUM_REGS; i++) begin
         if (wr_en[i]) begin
            regs[i] <= wr.wdata;
         end
      end
   end

   //################################################
   // read side
   //################################################

   assign rd_in_range = (addr < spi_slave_pkg::NUM_REGS);

   // tx shifter loads this on the falling edge
   assign rdata = rd_in_range ? regs[addr[spi_slave_pkg::IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

// File: hw/spi_slave.sv
//################################################
// spi slave top level
// interface block plus register file
// single clock sclk, ss as reset
//################################################

`timescale 1ns/1ps
`default_nettype none

module spi_slave (
   input  wire logic                  sclk,
   input  wire logic                  ss,
   input  wire logic                  mosi,
   input  wire logic                  lsbfirst,  // static config
   output logic                       miso,
   output spi_slave_pkg::reg_image_t  regs       // to core
);

   spi_slave_pkg::reg_wr_t            wr;     // write strobe, addr, data
   logic [spi_slave_pkg::ADDR_W-1:0]  addr;   // read address
   logic [spi_slave_pkg::BYTE_W-1:0]  rdata;  // read data back

   // serial side
   spi_slave_io i_spi_slave_io (
      .sclk     (sclk),
      .ss       (ss),
      .mosi     (mosi),
      .lsbfirst (lsbfirst),
      .miso     (miso),
      .rdata    (rdata),
      .wr       (wr),
      .addr     (addr)
   );

   // storage
   spi_regfile i_spi_regfile (
      .sclk  (sclk),
      .wr    (wr),
      .addr  (addr),
      .rdata (rdata),
      .regs  (regs)
   );

endmodule

`default_nettype wire

// File: hw/spi_slave_io.sv
//################################################
// spi slave interface for mode 0 only
// fsm, bit counter and byte strobes
// rx shift register on rising sclk
// command/address register with auto increment
// tx shift register and miso on falling sclk
//################################################

`timescale 1ns/1ps
`default_nettype none

module spi_slave_io (
   input  wire logic                                sclk,
   input  wire logic                                ss,       // active high async reset
   input  wire logic                                mosi,
   input  wire logic                                lsbfirst, // bit order both ways
   output logic                                     miso,
   input  wire logic [spi_slave_pkg::BYTE_W-1:0]    rdata,    // byte at addr
   output spi_slave_pkg::reg_wr_t                   wr,
   output logic [spi_slave_pkg::ADDR_W-1:0]         addr      // read address for next load
);

   spi_slave_pkg::spi_state_e         state_q;
   logic [2:0]                        bit_cnt_q;   // rising edges mod 8
   logic                              cmd_done_q;  // command byte complete
   logic                              data_done_q; // data byte complete
   spi_slave_pkg::spi_byte_u          rx_q;        // receive shifter
   spi_slave_pkg::spi_cmd_t           cmd_q;       // opcode and running address
   logic [spi_slave_pkg::BYTE_W-1:0]  tx_q;        // transmit shifter
   logic [spi_slave_pkg::ADDR_W-1:0]  addr_nxt;
   logic [1:0]                        op_nxt;
   logic                              tx_load;
   logic                              rd_active;

   //################################################
   // rising edge side
   //################################################

   // bit counter and byte strobes
   // strobes are high from edge 8n to edge 8n+1
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         bit_cnt_q   <= 3'd0;
         cmd_done_q  <= 1'b0;
         data_done_q <= 1'b0;
      end else begin
         bit_cnt_q   <= bit_cnt_q + 3'd1;
         cmd_done_q  <= (bit_cnt_q == 3'd7) && (state_q != spi_slave_pkg::DATA);
         data_done_q <= (bit_cnt_q == 3'd7) && (state_q == spi_slave_pkg::DATA);
      end
   end

   // receive shifter
   always_ff @(posedge sclk) begin
      if (lsbfirst) begin
         rx_q.raw <= {mosi, rx_q.raw[spi_slave_pkg::BYTE_W-1:1]}; // first bit ends in [0]
      end else begin
         rx_q.raw <= {rx_q.raw[spi_slave_pkg::BYTE_W-2:0], mosi}; // first bit ends in [7]
      end
   end

   //################################################
   // falling edge side
   //################################################

   // fsm leaves IDLE on the first falling edge after ss drops
   always_ff @(negedge sclk or posedge ss) begin
      if (ss) begin
         state_q <= spi_slave_pkg::IDLE;
      end else begin
         case (state_q)
            spi_slave_pkg::IDLE: state_q <= spi_slave_pkg::CMD;
            spi_slave_pkg::CMD: begin
               if (cmd_done_q) begin
                  state_q <= spi_slave_pkg::DATA;
               end
            end
            default: state_q <= spi_slave_pkg::DATA; // DATA holds until ss
         endcase
      end
   end

   // address and opcode after the coming falling edge
   always_comb begin
      addr_nxt = cmd_q.addr;
      op_nxt   = cmd_q.op;
      if (cmd_done_q) begin
         addr_nxt = rx_q.cmd.addr;      // command view of the byte
         op_nxt   = rx_q.cmd.op;
      end else if (data_done_q) begin
         addr_nxt = cmd_q.addr + 1'b1;  // wraps mod 64
      end
   end

   // command/address register
   always_ff @(negedge sclk or posedge ss) begin
      if (ss) begin
         cmd_q <= '0;
      end else if (cmd_done_q || data_done_q) begin
         cmd_q.op   <= op_nxt;
         cmd_q.addr <= addr_nxt;
      end
   end

   assign tx_load = cmd_done_q || data_done_q; // every byte boundary

   // transmit shifter
   // zero loaded for anything but a read
   always_ff @(negedge sclk) begin
      if (tx_load) begin
         tx_q <= (op_nxt == spi_slave_pkg::OP_READ) ? rdata : '0;
      end else if (lsbfirst) begin
         tx_q <= {1'b0, tx_q[spi_slave_pkg::BYTE_W-1:1]};
      end else begin
         tx_q <= {tx_q[spi_slave_pkg::BYTE_W-2:0], 1'b0};
      end
   end

   //################################################
   // outputs
   //################################################

   assign rd_active = (state_q == spi_slave_pkg::DATA) &&
                      (cmd_q.op == spi_slave_pkg::OP_READ);

   // miso only toggles during a read
   assign miso = rd_active ? (lsbfirst ? tx_q[0] : tx_q[spi_slave_pkg::BYTE_W-1]) : 1'b0;

   assign addr = addr_nxt; // regfile lookup for the tx load

   // write strobe taken by the regfile on the falling edge
   assign wr.write = data_done_q && (cmd_q.op == spi_slave_pkg::OP_WRITE);
   assign wr.addr  = cmd_q.addr;  // old address as the increment lands on the same edge
   assign wr.wdata = rx_q.raw;    // raw view of the byte

endmodule

`default_nettype wire

// File: hw/spi_slave_pkg.sv
//################################################
// shared sizes and opcodes for the spi slave
// fsm state encoding
// command byte view and received byte union
// register write bundle and register image type
//################################################

`default_nettype none

package spi_slave_pkg;

   //################################################
   // sizes
   //################################################
   localparam int NUM_REGS = 16;               // bytes in the register file
   localparam int ADDR_W   = 6;                // command address field
   localparam int BYTE_W   = 8;
   localparam int IDX_W    = $clog2(NUM_REGS); // index bits into the file

   //################################################
   // opcodes in the top two bits of the command byte
   //################################################
   localparam logic [1:0] OP_WRITE = 2'b00;
   localparam logic [1:0] OP_READ  = 2'b10;    // 01 and 11 do nothing

   // interface fsm
   typedef enum logic [1:0] {
      IDLE = 2'b00,                            // ss high
      CMD  = 2'b01,                            // shifting in command byte
      DATA = 2'b10                             // data bytes until ss rises
   } spi_state_e;

   // command byte layout
   typedef struct packed {
      logic [1:0]        op;
      logic [ADDR_W-1:0] addr;
   } spi_cmd_t;

   // one received byte with a command view in CMD and a raw view in DATA
   typedef union packed {
      spi_cmd_t          cmd;
      logic [BYTE_W-1:0] raw;
   } spi_byte_u;

   // write from interface to register file
   typedef struct packed {
      logic              write;                // one sclk period wide
      logic [ADDR_W-1:0] addr;
      logic [BYTE_W-1:0] wdata;
   } reg_wr_t;

   // whole register file as seen by the core
   typedef logic [NUM_REGS-1:0][BYTE_W-1:0] reg_image_t;

endpackage

`default_nettype wire

// File: verilog.f
hw/spi_slave_pkg.sv
hw/spi_slave_io.sv
hw/spi_regfile.sv
hw/spi_slave.sv
bench/spi_slave_asserts.sv
bench/tb_spi_slave.sv
